//--- tb.f
logic/riscv_id_pkg.sv
logic/id_pipe_reg.sv
logic/id_instr_check.sv
logic/id_operand_sel.sv
logic/id_hazard_unit.sv
logic/id_stage.sv
testbench/tb_clk_gen.sv
testbench/id_stage_assert.sv
testbench/tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_id_stage
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_id_stage.sv
// Table driven testbench for the ID stage with a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage;

  typedef struct {
    logic [31:0] instr;
    logic [63:0] pc;
    logic        bub;
    logic [32:0] ex;
    logic [32:0] mem;
    logic [32:0] wb;
    logic [1:0]  prv;
    logic        hold;
    logic [1:0]  flush;
    logic [63:0] npc;
  } row_t;

  localparam logic [32:0] NONE = {32'h0000_0013, 1'b1};

  logic clk, rstn, ex_stall, bu_flush, st_flush, if_bubble, st_tsr;
  logic [63:0] bu_nxt_pc, st_nxt_pc, if_pc, wb_r, id_pc, id_opA, id_opB;
  logic [31:0] if_instr, id_instr;
  logic [32:0] ex_info, mem_info, wb_info;
  logic [1:0]  st_prv;
  logic        id_bubble, id_stall;
  logic [15:0] id_exception;
  logic [4:0]  id_src1, id_src2;
  riscv_id_pkg::opnd_fwd_t id_fwd_a, id_fwd_b;

  row_t rows[$];
  int   limit = 0;
  int   cycles = 0;

  // Reference state of the ID registers
  logic [63:0] m_pc, m_opa, m_opb;
  logic [31:0] m_instr;
  logic        m_bub;
  logic [15:0] m_exc;
  logic [3:0]  m_fa, m_fb;

  tb_clk_gen u_clk_gen (.clk(clk), .rstn(rstn));

  id_stage #(.XLEN(64)) dut (.*);

  bind id_stage id_stage_assert u_assert (.*);

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic add_row(input logic [31:0] instr, input logic [63:0] pc, input logic bub,
                         input logic [32:0] ex, input logic [32:0] mem, input logic [32:0] wb,
                         input logic [1:0] prv, input logic hold, input logic [1:0] flush,
                         input logic [63:0] npc);
    row_t r;
    r = '{instr, pc, bub, ex, mem, wb, prv, hold, flush, npc};
    rows.push_back(r);
  endtask

  function automatic logic writes_rd(input logic [4:0] o);
    return o inside {5'h00, 5'h04, 5'h06, 5'h05, 5'h0C, 5'h0E, 5'h0D, 5'h1B, 5'h19, 5'h1C};
  endfunction

  function automatic logic reads_rs2(input logic [4:0] o);
    return o inside {5'h0C, 5'h0E, 5'h18, 5'h08};
  endfunction

  function automatic logic reads_rs1(input logic [4:0] o);
    return reads_rs2(o) || (o inside {5'h04, 5'h06, 5'h19, 5'h00, 5'h1C});
  endfunction

  // RV64I encodings plus the privilege rules for MRET and SRET
  function automatic logic is_illegal(input logic [31:0] i, input logic [1:0] prv);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = i[14:12];
    f7 = i[31:25];
    if (i[1:0] != 2'b11) return 1'b1;
    case (i[6:2])
      5'h0D, 5'h05, 5'h1B: return 1'b0;
      5'h19: return f3 != 0;
      5'h18: return f3 == 2 || f3 == 3;
      5'h00: return f3 == 7;
      5'h08: return f3 > 3;
      5'h03: return f3 > 1;
      5'h04: begin
        if (f3 == 1) return f7[6:1] != 0;
        if (f3 == 5) return f7[6:1] != 0 && f7[6:1] != 6'h10;
        return 1'b0;
      end
      5'h06: return !(f3 == 0 || (f3 == 1 && f7 == 0) || (f3 == 5 && (f7 == 0 || f7 == 7'h20)));
      5'h0C: return !(f7 == 0 || (f7 == 7'h20 && (f3 == 0 || f3 == 5)));
      5'h0E: return !((f7 == 0 && f3 inside {0, 1, 5}) || (f7 == 7'h20 && f3 inside {0, 5}));
      5'h1C: begin
        if (f3 != 0) return f3 == 4;
        if (i == 32'h0000_0073 || i == 32'h0010_0073) return 1'b0;
        if (i == 32'h3020_0073) return prv != 2'b11;
        if (i == 32'h1020_0073) return prv == 2'b00 || (prv == 2'b01 && st_tsr);
        return 1'b1;
      end
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic [15:0] exc_expect(input row_t r);
    logic [15:0] e;
    e = '0;
    if (!r.bub) begin
      e[2]  = is_illegal(r.instr, r.prv);
      e[3]  = r.instr == 32'h0010_0073;
      e[8]  = r.instr == 32'h0000_0073 && r.prv == 2'b00;
      e[9]  = r.instr == 32'h0000_0073 && r.prv == 2'b01;
      e[11] = r.instr == 32'h0000_0073 && r.prv == 2'b11;
    end
    return e;
  endfunction

  // Bits userf, bypex, bypmem, bypwb
  function automatic logic [3:0] fwd_expect(input logic used, input logic [4:0] s,
                                            input logic id_live, input row_t r);
    logic [3:0] f;
    f = '0;
    if (used) begin
      f[2] = id_live && writes_rd(m_instr[6:2]) && s == m_instr[11:7] && s != 0;
      f[1] = !r.ex[0] && writes_rd(r.ex[7:3]) && s == r.ex[12:8] && s != 0;
      f[0] = !r.mem[0] && writes_rd(r.mem[7:3]) && s == r.mem[12:8] && s != 0;
      f[3] = !(!r.wb[0] && writes_rd(r.wb[7:3]) && s == r.wb[12:8] && s != 0);
    end
    return f;
  endfunction

  task automatic apply_row(input row_t r);
    logic [63:0] immi, immu;
    logic        stall, flush, u1, u2, hit_id, hit_ex;
    logic [4:0]  s1, s2;
    if_instr = r.instr;
    if_pc = r.pc;
    if_bubble = r.bub;
    ex_info = r.ex;
    mem_info = r.mem;
    wb_info = r.wb;
    st_prv = r.prv;
    ex_stall = r.hold;
    st_flush = r.flush[1];
    bu_flush = r.flush[0];
    st_nxt_pc = r.flush[1] ? r.npc : ~r.npc;
    bu_nxt_pc = r.flush[0] ? r.npc : ~r.npc;
    wb_r = {$urandom, $urandom};
    #1;
    flush = |r.flush;
    s1 = r.instr[19:15];
    s2 = r.instr[24:20];
    u1 = reads_rs1(r.instr[6:2]);
    u2 = reads_rs2(r.instr[6:2]);
    hit_id = !r.bub && ((u1 && s1 == m_instr[11:7]) || (u2 && s2 == m_instr[11:7]));
    hit_ex = !r.bub && ((u1 && s1 == r.ex[12:8]) || (u2 && s2 == r.ex[12:8]));
    if (flush) stall = 1'b0;
    else if (r.hold) stall = !r.bub;
    else if (!m_bub && m_instr[6:2] == 5'h00) stall = hit_id;
    else if (!r.ex[0] && r.ex[7:3] == 5'h00) stall = hit_ex;
    else stall = 1'b0;
    check_value("id_stall", 64'(id_stall), 64'(stall));
    check_value("id_src1", 64'(id_src1), 64'(r.hold ? m_instr[19:15] : s1));
    check_value("id_src2", 64'(id_src2), 64'(r.hold ? m_instr[24:20] : s2));
    // Model update for the coming rising edge
    immi = {{52{r.instr[31]}}, r.instr[31:20]};
    immu = {{32{r.instr[31]}}, r.instr[31:12], 12'h000};
    if (flush) begin
      m_pc = r.npc;
      m_bub = 1'b1;
      m_exc = '0;
    end else if (!r.hold) begin
      m_bub = stall ? 1'b1 : r.bub;
      m_exc = stall ? '0 : exc_expect(r);
      if (!stall) m_pc = r.pc;
    end
    if (!r.hold) begin
      m_fa = fwd_expect(u1, s1, !m_bub_before(flush), r);
      m_fb = fwd_expect(u2, s2, !m_bub_before(flush), r);
      case (r.instr[6:2])
        5'h04, 5'h06, 5'h00, 5'h19: {m_opa, m_opb} = {wb_r, immi};
        5'h0C, 5'h0E, 5'h18, 5'h08: {m_opa, m_opb} = {wb_r, wb_r};
        5'h0D: {m_opa, m_opb} = {64'h0, immu};
        5'h05: {m_opa, m_opb} = {r.pc, immu};
        5'h1C: {m_opa, m_opb} = {wb_r, 59'h0, s1};
        default: {m_opa, m_opb} = '0;
      endcase
      m_instr = r.instr;
    end
    @(negedge clk);
    check_value("id_pc", id_pc, m_pc);
    check_value("id_instr", 64'(id_instr), 64'(m_instr));
    check_value("id_bubble", 64'(id_bubble), 64'(m_bub | r.hold | flush));
    check_value("id_exception", 64'(id_exception), 64'(m_exc));
    check_value("id_opA", id_opA, m_opa);
    check_value("id_opB", id_opB, m_opb);
    check_value("id_fwd_a", 64'(id_fwd_a), 64'(m_fa));
    check_value("id_fwd_b", 64'(id_fwd_b), 64'(m_fb));
  endtask

  // ID bubble as seen by the forwarding logic before the update
  logic prev_bub;
  function automatic logic m_bub_before(input logic flush);
    return prev_bub | flush;
  endfunction

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout, the table did not finish in %0d cycles", limit);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  initial begin
    void'($urandom(23));
    {ex_stall, bu_flush, st_flush, st_tsr, if_bubble} = 5'b00001;
    {bu_nxt_pc, st_nxt_pc, if_pc, wb_r} = '0;
    {if_instr, ex_info, mem_info, wb_info, st_prv} = {32'h13, NONE, NONE, NONE, 2'b11};
    add_row(32'hFFB1_0093, 64'h1000, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h8000_11B7, 64'h1004, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h1234_5217, 64'h1008, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h0063_A423, 64'h100C, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'hFFB1_0093, 64'h1010, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h00B0_8533, 64'h1014, 0, NONE, {32'h0010_0593, 1'b0},
            {32'hFFB1_0093, 1'b0}, 3, 0, 0, 0);
    add_row(32'h0005_8633, 64'h1018, 0, {32'h13, 1'b0}, {32'h0010_0593, 1'b1},
            NONE, 3, 0, 0, 0);
    add_row(32'h0000_A283, 64'h101C, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h0092_8433, 64'h1020, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h0092_8433, 64'h1020, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h0000_0073, 64'h1024, 0, NONE, NONE, NONE, 0, 0, 0, 0);
    add_row(32'h0000_0073, 64'h1028, 0, NONE, NONE, NONE, 1, 0, 0, 0);
    add_row(32'h0000_0073, 64'h102C, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h0010_0073, 64'h1030, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h3020_0073, 64'h1034, 0, NONE, NONE, NONE, 1, 0, 0, 0);
    add_row(32'h0000_007F, 64'h1038, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h0292_8433, 64'h103C, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h0000_0073, 64'h1040, 1, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'hFFB1_0093, 64'h1044, 0, NONE, NONE, NONE, 3, 0, 2, 64'h8000);
    add_row(32'h00B0_8533, 64'h8010, 0, NONE, NONE, NONE, 3, 1, 0, 0);
    add_row(32'h00B0_8533, 64'h8010, 0, NONE, NONE, NONE, 3, 1, 0, 0);
    add_row(32'h00B0_8533, 64'h8000, 0, NONE, NONE, NONE, 3, 0, 0, 0);
    add_row(32'h8000_11B7, 64'h8004, 0, NONE, NONE, NONE, 3, 0, 1, 64'h9000);
    add_row(32'h0000_0013, 64'h9000, 1, NONE, NONE, NONE, 3, 0, 0, 0);
    limit = rows.size() * 4 + 20;
    wait (rstn);
    #1;
    check_value("id_bubble", 64'(id_bubble), 64'h1);
    check_value("id_exception", 64'(id_exception), 64'h0);
    check_value("id_pc", id_pc, riscv_id_pkg::PC_INIT);
    @(negedge clk);
    // The idle fetch slot entered ID at the first edge after reset
    {m_pc, m_bub, m_exc, m_instr} = {if_pc, 1'b1, 16'h0, if_instr};
    foreach (rows[i]) begin
      prev_bub = m_bub;
      apply_row(rows[i]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/id_stage_assert.sv
// Concurrent assertions on the ID stage ports
`timescale 1ns/10ps
`default_nettype none

module id_stage_assert (
  input wire logic                   clk,
  input wire logic                   rstn,
  input wire logic                   bu_flush,
  input wire logic                   st_flush,
  input wire logic                   id_stall,
  input wire logic                   id_bubble,
  input wire riscv_id_pkg::exc_vec_t id_exception
);

  // No load-use stall while the pipe is redirected
  a_no_stall_on_flush: assert property (@(posedge clk) disable iff (!rstn)
    (bu_flush || st_flush) |-> !id_stall)
    else $error("id_stall high during a flush");

  a_bubble_after_flush: assert property (@(posedge clk) disable iff (!rstn)
    (bu_flush || st_flush) |=> id_bubble)
    else $error("id_bubble low in the cycle after a flush");

  // Breakpoint and the three ecall causes exclude each other
  a_single_trap: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({id_exception[3], id_exception[8], id_exception[9], id_exception[11]}))
    else $error("more than one ecall or breakpoint bit set");

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
// Clock and reset source for the ID stage testbench
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk  = 1'b0;
    rstn = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held for 4 cycles, released away from the rising edge
  initial begin
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/id_stage.sv
// Instruction decode stage top, connects pipe register, legality check,
// operand select and hazard unit
`timescale 1ns/10ps
`default_nettype none

module id_stage #(
  parameter int XLEN = 64
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ex_stall,
  input  logic                      bu_flush,
  input  logic [XLEN-1:0]           bu_nxt_pc,
  input  logic                      st_flush,
  input  logic [XLEN-1:0]           st_nxt_pc,
  input  logic [XLEN-1:0]           if_pc,
  input  riscv_id_pkg::instr_t      if_instr,
  input  logic                      if_bubble,
  input  riscv_id_pkg::stage_info_t ex_info,
  input  riscv_id_pkg::stage_info_t mem_info,
  input  riscv_id_pkg::stage_info_t wb_info,
  input  riscv_id_pkg::prv_t        st_prv,
  input  logic                      st_tsr,
  input  logic [XLEN-1:0]           wb_r,
  output logic [XLEN-1:0]           id_pc,
  output riscv_id_pkg::instr_t      id_instr,
  output logic                      id_bubble,
  output riscv_id_pkg::exc_vec_t    id_exception,
  output logic                      id_stall,
  output riscv_id_pkg::reg_addr_t   id_src1,
  output riscv_id_pkg::reg_addr_t   id_src2,
  output logic [XLEN-1:0]           id_opA,
  output logic [XLEN-1:0]           id_opB,
  output riscv_id_pkg::opnd_fwd_t   id_fwd_a,
  output riscv_id_pkg::opnd_fwd_t   id_fwd_b
);

  riscv_id_pkg::exc_vec_t exc_next;

  // Exception causes for the fetched slot
  id_instr_check u_instr_check (
    .if_instr (if_instr),
    .if_bubble(if_bubble),
    .st_prv   (st_prv),
    .st_tsr   (st_tsr),
    .exc_next (exc_next)
  );

  id_pipe_reg #(
    .XLEN(XLEN)
  ) u_pipe_reg (
    .clk         (clk),
    .rstn        (rstn),
    .ex_stall    (ex_stall),
    .bu_flush    (bu_flush),
    .st_flush    (st_flush),
    .bu_nxt_pc   (bu_nxt_pc),
    .st_nxt_pc   (st_nxt_pc),
    .if_pc       (if_pc),
    .if_instr    (if_instr),
    .if_bubble   (if_bubble),
    .exc_next    (exc_next),
    .id_stall    (id_stall),
    .id_pc       (id_pc),
    .id_instr    (id_instr),
    .id_bubble   (id_bubble),
    .id_exception(id_exception),
    .id_src1     (id_src1),
    .id_src2     (id_src2)
  );

  id_operand_sel #(
    .XLEN(XLEN)
  ) u_operand_sel (
    .clk     (clk),
    .if_pc   (if_pc),
    .if_instr(if_instr),
    .wb_r    (wb_r),
    .ex_stall(ex_stall),
    .id_opA  (id_opA),
    .id_opB  (id_opB)
  );

  // Stall feeds back into the pipe register
  id_hazard_unit u_hazard_unit (
    .clk      (clk),
    .rstn     (rstn),
    .ex_stall (ex_stall),
    .bu_flush (bu_flush),
    .st_flush (st_flush),
    .if_instr (if_instr),
    .if_bubble(if_bubble),
    .id_instr (id_instr),
    .id_bubble(id_bubble),
    .ex_info  (ex_info),
    .mem_info (mem_info),
    .wb_info  (wb_info),
    .id_stall (id_stall),
    .id_fwd_a (id_fwd_a),
    .id_fwd_b (id_fwd_b)
  );

endmodule

`default_nettype wire

//--- logic/id_hazard_unit.sv
// Registered operand forwarding selects and combinational load-use stall
`timescale 1ns/10ps
`default_nettype none

module id_hazard_unit (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ex_stall,
  input  logic                      bu_flush,
  input  logic                      st_flush,
  input  riscv_id_pkg::instr_t      if_instr,
  input  logic                      if_bubble,
  input  riscv_id_pkg::instr_t      id_instr,
  input  logic                      id_bubble,
  input  riscv_id_pkg::stage_info_t ex_info,
  input  riscv_id_pkg::stage_info_t mem_info,
  input  riscv_id_pkg::stage_info_t wb_info,
  output logic                      id_stall,
  output riscv_id_pkg::opnd_fwd_t   id_fwd_a,
  output riscv_id_pkg::opnd_fwd_t   id_fwd_b
);

  riscv_id_pkg::opcode_t   if_opc;
  riscv_id_pkg::reg_addr_t if_src1;
  riscv_id_pkg::reg_addr_t if_src2;
  logic                    use_rs1;
  logic                    use_rs2;

  riscv_id_pkg::reg_addr_t id_dst;
  riscv_id_pkg::reg_addr_t ex_dst;
  riscv_id_pkg::reg_addr_t mem_dst;
  riscv_id_pkg::reg_addr_t wb_dst;

  logic can_bypex;
  logic can_bypmem;
  logic can_bypwb;
  logic can_ldwb;
  logic id_load;
  logic ex_load;

  assign if_opc  = if_instr[6:2];
  assign if_src1 = if_instr[19:15];
  assign if_src2 = if_instr[24:20];
  assign use_rs1 = riscv_id_pkg::uses_rs1(if_opc);
  assign use_rs2 = riscv_id_pkg::uses_rs2(if_opc);

  assign id_dst  = id_instr[11:7];
  assign ex_dst  = ex_info.instr[11:7];
  assign mem_dst = mem_info.instr[11:7];
  assign wb_dst  = wb_info.instr[11:7];

  // A stage can supply a result if it holds a writing, live instruction
  assign can_bypex  = riscv_id_pkg::has_rd(id_instr[6:2]) & ~id_bubble;
  assign can_bypmem = riscv_id_pkg::has_rd(ex_info.instr[6:2]) & ~ex_info.bubble;
  assign can_bypwb  = riscv_id_pkg::has_rd(mem_info.instr[6:2]) & ~mem_info.bubble;
  assign can_ldwb   = riscv_id_pkg::has_rd(wb_info.instr[6:2]) & ~wb_info.bubble;

  // x0 never forwards
  function automatic riscv_id_pkg::opnd_fwd_t fwd_sel(
    input logic                    used,
    input riscv_id_pkg::reg_addr_t src
  );
    riscv_id_pkg::opnd_fwd_t sel;
    sel = '0;
    if (used) begin
      sel.bypex  = can_bypex  & (src == id_dst)  & (|id_dst);
      sel.bypmem = can_bypmem & (src == ex_dst)  & (|ex_dst);
      sel.bypwb  = can_bypwb  & (src == mem_dst) & (|mem_dst);
      // WB result not yet in the register file
      sel.userf  = ~(can_ldwb & (src == wb_dst) & (|wb_dst));
    end
    return sel;
  endfunction

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_fwd_a <= '0;
      id_fwd_b <= '0;
    end else if (!ex_stall) begin
      id_fwd_a <= fwd_sel(use_rs1, if_src1);
      id_fwd_b <= fwd_sel(use_rs2, if_src2);
    end
  end

  //////////////////////////////
  // Load-use stall
  //////////////////////////////
  function automatic logic src_hit(input riscv_id_pkg::reg_addr_t dst);
    return ~if_bubble & ((use_rs1 & (if_src1 == dst)) | (use_rs2 & (if_src2 == dst)));
  endfunction

  assign id_load = (id_instr[6:2] == riscv_id_pkg::OPC_LOAD) & ~id_bubble;
  assign ex_load = (ex_info.instr[6:2] == riscv_id_pkg::OPC_LOAD) & ~ex_info.bubble;

  always_comb begin
    if (bu_flush || st_flush) begin
      id_stall = 1'b0;
    end else if (ex_stall) begin
      id_stall = ~if_bubble;
    end else if (id_load) begin
      id_stall = src_hit(id_dst);
    end else if (ex_load) begin
      id_stall = src_hit(ex_dst);
    end else begin
      id_stall = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/id_operand_sel.sv
// Immediate decode and registered operand A/B select
`timescale 1ns/10ps
`default_nettype none

module id_operand_sel #(
  parameter int XLEN = 64
) (
  input  logic                 clk,
  input  logic [XLEN-1:0]      if_pc,
  input  riscv_id_pkg::instr_t if_instr,
  input  logic [XLEN-1:0]      wb_r,
  input  logic                 ex_stall,
  output logic [XLEN-1:0]      id_opA,
  output logic [XLEN-1:0]      id_opB
);

  riscv_id_pkg::opcode_t    opcode;
  riscv_id_pkg::reg_addr_t  rs1;
  logic [XLEN-1:0]          imm_i;
  logic [XLEN-1:0]          imm_u;
  logic [XLEN-1:0]          opa_next;
  logic [XLEN-1:0]          opb_next;

  assign opcode = if_instr[6:2];
  assign rs1    = if_instr[19:15];

  // Sign extended I and U immediates
  assign imm_i = {{(XLEN-11){if_instr[31]}}, if_instr[30:20]};
  assign imm_u = {{(XLEN-31){if_instr[31]}}, if_instr[30:12], 12'b0};

  always_comb begin
    case (opcode)
      riscv_id_pkg::OPC_OP_IMM,
      riscv_id_pkg::OPC_OP_IMM32,
      riscv_id_pkg::OPC_LOAD,
      riscv_id_pkg::OPC_JALR: begin
        opa_next = wb_r;
        opb_next = imm_i;
      end
      riscv_id_pkg::OPC_OP,
      riscv_id_pkg::OPC_OP32,
      riscv_id_pkg::OPC_BRANCH,
      riscv_id_pkg::OPC_STORE: begin
        opa_next = wb_r;
        opb_next = wb_r;
      end
      riscv_id_pkg::OPC_LUI: begin
        opa_next = '0;
        opb_next = imm_u;
      end
      riscv_id_pkg::OPC_AUIPC: begin
        opa_next = if_pc;
        opb_next = imm_u;
      end
      riscv_id_pkg::OPC_SYSTEM: begin
        // CSRxxI takes the rs1 field as a zimm
        opa_next = wb_r;
        opb_next = {{(XLEN-5){1'b0}}, rs1};
      end
      default: begin
        opa_next = '0;
        opb_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!ex_stall) begin
      id_opA <= opa_next;
      id_opB <= opb_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/id_instr_check.sv
// Legality check and exception cause decode of the fetched instruction
`timescale 1ns/10ps
`default_nettype none

module id_instr_check (
  input  riscv_id_pkg::instr_t   if_instr,
  input  logic                   if_bubble,
  input  riscv_id_pkg::prv_t     st_prv,
  input  logic                   st_tsr,
  output riscv_id_pkg::exc_vec_t exc_next
);

  riscv_id_pkg::opcode_t opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  illegal;
  logic                  is_ecall;

  assign opcode   = if_instr[6:2];
  assign funct3   = if_instr[14:12];
  assign funct7   = if_instr[31:25];
  assign is_ecall = (if_instr == riscv_id_pkg::ECALL);

  //////////////////////////////
  // RV64I legality
  //////////////////////////////
  always_comb begin
    illegal = 1'b1;
    if (if_instr[1:0] == 2'b11) begin
      case (opcode)
        riscv_id_pkg::OPC_LUI,
        riscv_id_pkg::OPC_AUIPC,
        riscv_id_pkg::OPC_JAL:      illegal = 1'b0;
        riscv_id_pkg::OPC_JALR:     illegal = (funct3 != 3'b000);
        riscv_id_pkg::OPC_BRANCH:   illegal = (funct3[2:1] == 2'b01);
        // LB through LWU, nothing at funct3 7
        riscv_id_pkg::OPC_LOAD:     illegal = (funct3 == 3'b111);
        riscv_id_pkg::OPC_STORE:    illegal = funct3[2];
        riscv_id_pkg::OPC_MISC_MEM: illegal = (funct3[2:1] != 2'b00);
        riscv_id_pkg::OPC_OP_IMM: begin
          // Shifts carry a 6-bit shamt, bit 25 is free
          case (funct3)
            3'b001:  illegal = (funct7[6:1] != 6'b000000);
            3'b101:  illegal = (funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000);
            default: illegal = 1'b0;
          endcase
        end
        riscv_id_pkg::OPC_OP_IMM32: begin
          case (funct3)
            3'b000:  illegal = 1'b0;
            3'b001:  illegal = (funct7 != 7'h00);
            3'b101:  illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
            default: illegal = 1'b1;
          endcase
        end
        riscv_id_pkg::OPC_OP: begin
          if (funct7 == 7'h00) illegal = 1'b0;
          else if (funct7 == 7'h20) illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end
        riscv_id_pkg::OPC_OP32: begin
          if (funct7 == 7'h00) begin
            illegal = (funct3 != 3'b000) && (funct3 != 3'b001) && (funct3 != 3'b101);
          end else if (funct7 == 7'h20) begin
            illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
          end
        end
        riscv_id_pkg::OPC_SYSTEM: begin
          if (funct3 == 3'b000) begin
            case (if_instr)
              riscv_id_pkg::ECALL,
              riscv_id_pkg::EBREAK: illegal = 1'b0;
              riscv_id_pkg::MRET:   illegal = (st_prv != riscv_id_pkg::PRV_M);
              riscv_id_pkg::SRET:   illegal = (st_prv == riscv_id_pkg::PRV_U) ||
                                              (st_prv == riscv_id_pkg::PRV_S && st_tsr);
              default:              illegal = 1'b1;
            endcase
          end else begin
            // CSR access, funct3 4 is reserved
            illegal = (funct3 == 3'b100);
          end
        end
        default: illegal = 1'b1;
      endcase
    end
  end

  // Causes, all masked for an empty fetch slot
  always_comb begin
    exc_next = '0;
    exc_next[riscv_id_pkg::CAUSE_ILLEGAL_INSTRUCTION] = ~if_bubble & illegal;
    exc_next[riscv_id_pkg::CAUSE_BREAKPOINT] =
      ~if_bubble & (if_instr == riscv_id_pkg::EBREAK);
    exc_next[riscv_id_pkg::CAUSE_UMODE_ECALL] =
      ~if_bubble & is_ecall & (st_prv == riscv_id_pkg::PRV_U);
    exc_next[riscv_id_pkg::CAUSE_SMODE_ECALL] =
      ~if_bubble & is_ecall & (st_prv == riscv_id_pkg::PRV_S);
    exc_next[riscv_id_pkg::CAUSE_MMODE_ECALL] =
      ~if_bubble & is_ecall & (st_prv == riscv_id_pkg::PRV_M);
  end

endmodule

`default_nettype wire

//--- logic/id_pipe_reg.sv
// IF/ID pipeline register for PC, instruction, bubble and exceptions
// plus the register file source address mux
`timescale 1ns/10ps
`default_nettype none

module id_pipe_reg #(
  parameter int XLEN = 64
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    ex_stall,
  input  logic                    bu_flush,
  input  logic                    st_flush,
  input  logic [XLEN-1:0]         bu_nxt_pc,
  input  logic [XLEN-1:0]         st_nxt_pc,
  input  logic [XLEN-1:0]         if_pc,
  input  riscv_id_pkg::instr_t    if_instr,
  input  logic                    if_bubble,
  input  riscv_id_pkg::exc_vec_t  exc_next,
  input  logic                    id_stall,
  output logic [XLEN-1:0]         id_pc,
  output riscv_id_pkg::instr_t    id_instr,
  output logic                    id_bubble,
  output riscv_id_pkg::exc_vec_t  id_exception,
  output riscv_id_pkg::reg_addr_t id_src1,
  output riscv_id_pkg::reg_addr_t id_src2
);

  logic hold;
  logic flush;
  logic bubble_r;

  assign hold  = ex_stall;
  assign flush = bu_flush | st_flush;

  // Flush wins over hold, hold wins over the load-use stall
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_pc        <= riscv_id_pkg::PC_INIT[XLEN-1:0];
      bubble_r     <= 1'b1;
      id_exception <= '0;
    end else if (st_flush) begin
      id_pc        <= st_nxt_pc;
      bubble_r     <= 1'b1;
      id_exception <= '0;
    end else if (bu_flush) begin
      id_pc        <= bu_nxt_pc;
      bubble_r     <= 1'b1;
      id_exception <= '0;
    end else if (!hold) begin
      if (id_stall) begin
        // PC kept, a bubble goes down the pipe
        bubble_r     <= 1'b1;
        id_exception <= '0;
      end else begin
        id_pc        <= if_pc;
        bubble_r     <= if_bubble;
        id_exception <= exc_next;
      end
    end
  end

  // Instruction word, qualified by the bubble flag
  always_ff @(posedge clk) begin
    if (!hold) begin
      id_instr <= if_instr;
    end
  end

  assign id_bubble = bubble_r | hold | flush;

  // Register file reads the held instruction while EX is stalled
  assign id_src1 = hold ? id_instr[19:15] : if_instr[19:15];
  assign id_src2 = hold ? id_instr[24:20] : if_instr[24:20];

endmodule

`default_nettype wire

//--- logic/riscv_id_pkg.sv
// Shared types, opcodes, exception causes and privilege levels
// for the RV64I instruction decode stage
`default_nettype none

package riscv_id_pkg;

  //////////////////////////////
  // Field types
  //////////////////////////////
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  opcode_t;
  typedef logic [1:0]  prv_t;
  typedef logic [15:0] exc_vec_t;

  // Major opcodes, instruction bits 6:2
  localparam opcode_t OPC_LOAD     = 5'b00000;
  localparam opcode_t OPC_MISC_MEM = 5'b00011;
  localparam opcode_t OPC_OP_IMM   = 5'b00100;
  localparam opcode_t OPC_AUIPC    = 5'b00101;
  localparam opcode_t OPC_OP_IMM32 = 5'b00110;
  localparam opcode_t OPC_STORE    = 5'b01000;
  localparam opcode_t OPC_OP       = 5'b01100;
  localparam opcode_t OPC_LUI      = 5'b01101;
  localparam opcode_t OPC_OP32     = 5'b01110;
  localparam opcode_t OPC_BRANCH   = 5'b11000;
  localparam opcode_t OPC_JALR     = 5'b11001;
  localparam opcode_t OPC_JAL      = 5'b11011;
  localparam opcode_t OPC_SYSTEM   = 5'b11100;

  // Full system instruction encodings
  localparam instr_t ECALL  = 32'h0000_0073;
  localparam instr_t EBREAK = 32'h0010_0073;
  localparam instr_t SRET   = 32'h1020_0073;
  localparam instr_t MRET   = 32'h3020_0073;

  localparam prv_t PRV_U = 2'b00;
  localparam prv_t PRV_S = 2'b01;
  localparam prv_t PRV_M = 2'b11;

  // Bit positions in exc_vec_t
  localparam int CAUSE_ILLEGAL_INSTRUCTION = 2;
  localparam int CAUSE_BREAKPOINT          = 3;
  localparam int CAUSE_UMODE_ECALL         = 8;
  localparam int CAUSE_SMODE_ECALL         = 9;
  localparam int CAUSE_MMODE_ECALL         = 11;

  localparam logic [63:0] PC_INIT = 64'h200;

  //////////////////////////////
  // Pipeline structs
  //////////////////////////////
  typedef struct packed {
    instr_t instr;
    logic   bubble;
  } stage_info_t;

  // Operand source select, one hot except for userf
  typedef struct packed {
    logic userf;
    logic bypex;
    logic bypmem;
    logic bypwb;
  } opnd_fwd_t;

  // Opcodes that write a result into rd
  function automatic logic has_rd(input opcode_t opc);
    case (opc)
      OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM32, OPC_AUIPC, OPC_OP, OPC_OP32,
      OPC_LUI, OPC_JAL, OPC_JALR, OPC_SYSTEM: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic uses_rs2(input opcode_t opc);
    case (opc)
      OPC_OP, OPC_OP32, OPC_BRANCH, OPC_STORE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic uses_rs1(input opcode_t opc);
    case (opc)
      OPC_OP_IMM, OPC_OP_IMM32, OPC_JALR, OPC_LOAD, OPC_SYSTEM: return 1'b1;
      default: return uses_rs2(opc);
    endcase
  endfunction

endpackage

`default_nettype wire
